/* Bender.yml */
package:
  name: msx_slots

sources:
  - design/msx_pkg.sv
  - design/slot_expander.sv
  - design/msx2_ram_mapper.sv
  - design/cart_konami.sv
  - design/cart_ascii8.sv
  - design/cart_ascii16.sv
  - design/msx_slots.sv
  - target: test
    files:
      - verif/tb_msx_slots.sv

/* design/cart_ascii16.sv */
`default_nettype none
`timescale 1ns/10ps

module cart_ascii16 (
   input  wire                             clk,
   input  wire                             reset,
   input  msx_pkg::cpu_bus_t               cpu,
   input  wire                             cs,
   input  wire [msx_pkg::ROM_AW-1:0]       rom_size,
   output logic [msx_pkg::ROM_AW-1:0]      mem_addr,
   output logic                            mem_unmapped
);

   logic [7:0] bank [2];
   logic       in_range;
   logic       wr_cycle;

   assign in_range = (cpu.addr[15:14] == 2'b01) | (cpu.addr[15:14] == 2'b10);
   assign wr_cycle = cs & cpu.mreq & cpu.wr;

   // 6000..67FF bank 0, 7000..77FF bank 1
   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'h00;
         bank[1] <= 8'h00;
      end else if (wr_cycle) begin
         if (cpu.addr[15:11] == 5'b01100) begin
            bank[0] <= cpu.dout;
         end
         if (cpu.addr[15:11] == 5'b01110) begin
            bank[1] <= cpu.dout;
         end
      end
   end

   // 4000..7FFF uses bank 0, 8000..BFFF bank 1
   always_comb begin
      mem_addr = msx_pkg::ROM_AW'({bank[cpu.addr[15]], cpu.addr[13:0]});
      mem_addr = mem_addr & (rom_size - 1'b1);
   end

   assign mem_unmapped = cs & ~in_range;

endmodule

`default_nettype wire

/* design/cart_ascii8.sv */
`default_nettype none
`timescale 1ns/10ps

module cart_ascii8 (
   input  wire                             clk,
   input  wire                             reset,
   input  msx_pkg::cpu_bus_t               cpu,
   input  wire                             cs,
   input  wire [msx_pkg::ROM_AW-1:0]       rom_size,
   output logic [msx_pkg::ROM_AW-1:0]      mem_addr,
   output logic                            mem_unmapped
);

   logic [7:0] bank [4];
   logic [1:0] window;
   logic       in_range;
   logic       bank_wr;

   assign in_range = (cpu.addr[15:14] == 2'b01) | (cpu.addr[15:14] == 2'b10);
   assign window   = 2'(cpu.addr[15:13] - 3'd2);

   // 6000..7FFF, 2 kB per bank register
   assign bank_wr = cs & cpu.mreq & cpu.wr & (cpu.addr[15:13] == 3'b011);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            bank[i] <= 8'h00;
         end
      end else if (bank_wr) begin
         bank[cpu.addr[12:11]] <= cpu.dout;
      end
   end

   always_comb begin
      mem_addr = msx_pkg::ROM_AW'({bank[window], cpu.addr[12:0]});
      mem_addr = mem_addr & (rom_size - 1'b1);
   end

   // Outside the cartridge window
   assign mem_unmapped = cs & ~in_range;

endmodule

`default_nettype wire

/* design/cart_konami.sv */
`default_nettype none
`timescale 1ns/10ps

module cart_konami (
   input  wire                             clk,
   input  wire                             reset,
   input  msx_pkg::cpu_bus_t               cpu,
   input  wire                             cs,
   input  wire [msx_pkg::ROM_AW-1:0]       rom_size,
   output logic [msx_pkg::ROM_AW-1:0]      mem_addr,
   output logic                            mem_unmapped
);

   logic [7:0] bank [4];
   logic [1:0] window;
   logic       in_range;
   logic       bank_wr;

   // 4000..BFFF in four 8 kB windows
   assign in_range = (cpu.addr[15:14] == 2'b01) | (cpu.addr[15:14] == 2'b10);
   assign window   = 2'(cpu.addr[15:13] - 3'd2);

   // Window 0 has no register
   assign bank_wr = cs & cpu.mreq & cpu.wr & in_range & (window != 2'd0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            bank[i] <= 8'(i);
         end
      end else if (bank_wr) begin
         bank[window] <= cpu.dout;
      end
   end

   always_comb begin
      mem_addr = msx_pkg::ROM_AW'({bank[window], cpu.addr[12:0]});
      mem_addr = mem_addr & (rom_size - 1'b1);   // Wrap to ROM size
   end

   assign mem_unmapped = cs & ~in_range;

endmodule

`default_nettype wire

/* design/msx2_ram_mapper.sv */
`default_nettype none
`timescale 1ns/10ps

module msx2_ram_mapper (
   input  wire                                   clk,
   input  wire                                   reset,
   input  msx_pkg::cpu_bus_t                     cpu,
   input  wire                                   cs,
   input  wire [7:0]                             ram_block_count,
   output logic [msx_pkg::RAM_MAPPER_AW-1:0]     mapper_addr,
   output logic [7:0]                            mapper_dout
);

   logic [7:0] segment [4];   // Page 0..3
   logic [7:0] seg_mask;
   logic [7:0] page_seg;
   logic       port_hit;
   logic       mapper_en;

   // FC..FF, M1 cycles are interrupt acknowledge
   assign port_hit = cpu.iorq & ~cpu.m1 & (cpu.addr[7:2] == msx_pkg::RAM_MAPPER_PORT[7:2]);

   assign mapper_en = |ram_block_count;
   assign seg_mask  = ram_block_count - 8'd1;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            segment[i] <= 8'(3 - i);   // Boot layout 3, 2, 1, 0
         end
      end else if (port_hit & cpu.wr & mapper_en) begin
         segment[cpu.addr[1:0]] <= cpu.dout;
      end
   end

   assign page_seg = segment[cpu.addr[15:14]] & seg_mask;

   always_comb begin
      mapper_addr = '0;
      if (cs) begin
         mapper_addr = {page_seg, cpu.addr[13:0]};
      end
   end

   // Unused high bits read as 1
   always_comb begin
      mapper_dout = msx_pkg::UNMAPPED_DATA;
      if (port_hit & cpu.rd) begin
         mapper_dout = segment[cpu.addr[1:0]] | ~seg_mask;
      end
   end

endmodule

`default_nettype wire

/* design/msx_pkg.sv */
`default_nettype none

package msx_pkg;

   // Memory widths
   localparam int RAM_AW        = 27;
   localparam int ROM_AW        = 25;
   localparam int RAM_MAPPER_AW = 22;

   // Configuration table sizes
   localparam int LAYOUT_ENTRIES = 64;   // slot, subslot, block
   localparam int RAM_LOOKUPS    = 16;

   localparam logic [15:0] EXPANDER_ADDR   = 16'hFFFF;
   localparam logic [7:0]  RAM_MAPPER_PORT = 8'hFC;   // FC..FF, one per page
   localparam logic [7:0]  UNMAPPED_DATA   = 8'hFF;

   typedef enum logic [2:0] {
      MAPPER_UNUSED  = 3'd0,
      MAPPER_NONE    = 3'd1,
      MAPPER_LINEAR  = 3'd2,
      MAPPER_RAM     = 3'd3,
      MAPPER_KONAMI  = 3'd4,
      MAPPER_ASCII8  = 3'd5,
      MAPPER_ASCII16 = 3'd6
   } mapper_t;

   // One 16 kB block of a slot/subslot
   typedef struct packed {
      logic [3:0] ref_ram;      // Index into lookup_ram
      logic [1:0] offset_ram;   // Block offset for MAPPER_NONE
      mapper_t    mapper;
      logic       spare;
   } block_t;

   // Memory region
   typedef struct packed {
      logic [RAM_AW-1:0] addr;
      logic [15:0]       size;   // In 16 kB units
      logic              ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;   // Per primary slot
      logic [7:0] ram_block_count;    // RAM mapper segments, power of two
   } bios_config_t;

   // Z80 side of the bus, strobes are plain levels
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        wr;
      logic        rd;
      logic        mreq;
      logic        iorq;
      logic        m1;
   } cpu_bus_t;

endpackage

`default_nettype wire

/* design/msx_slots.sv */
`default_nettype none
`timescale 1ns/10ps

module msx_slots (
   input  wire                            clk,
   input  wire                            reset,
   input  msx_pkg::cpu_bus_t              cpu,
   input  wire [1:0]                      active_slot,
   input  msx_pkg::block_t                slot_layout [msx_pkg::LAYOUT_ENTRIES],
   input  msx_pkg::lookup_ram_t           lookup_ram [msx_pkg::RAM_LOOKUPS],
   input  msx_pkg::bios_config_t          bios_config,
   input  wire [7:0]                      ram_dout,
   output logic [7:0]                     cpu_din,
   output logic [msx_pkg::RAM_AW-1:0]     ram_addr,
   output logic [7:0]                     ram_din,
   output logic                           ram_rnw,
   output logic                           ram_ce
);

   logic [1:0]                        subslot;
   logic                              expander_hit;
   logic [7:0]                        expander_dout;
   logic [5:0]                        layout_id;
   msx_pkg::block_t                   blk;
   msx_pkg::lookup_ram_t              region;
   msx_pkg::mapper_t                  mapper;
   logic [msx_pkg::RAM_AW-1:0]        size_mask;
   logic [msx_pkg::ROM_AW-1:0]        rom_size;
   logic [msx_pkg::RAM_AW-1:0]        none_addr;
   logic [msx_pkg::RAM_AW-1:0]        linear_addr;
   logic [msx_pkg::RAM_AW-1:0]        mapper_offset;
   logic [msx_pkg::RAM_MAPPER_AW-1:0] ram_mapper_addr;
   logic [7:0]                        ram_mapper_dout;
   logic [msx_pkg::ROM_AW-1:0]        konami_addr;
   logic [msx_pkg::ROM_AW-1:0]        ascii8_addr;
   logic [msx_pkg::ROM_AW-1:0]        ascii16_addr;
   logic                              konami_unmapped;
   logic                              ascii8_unmapped;
   logic                              ascii16_unmapped;
   logic                              mem_unmapped;
   logic                              mem_access;
   logic                              mem_wr;

   // Slot, subslot, page
   assign layout_id = {active_slot, subslot, cpu.addr[15:14]};
   assign blk       = slot_layout[layout_id];
   assign region    = lookup_ram[blk.ref_ram];
   assign mapper    = blk.mapper;

   assign size_mask = (msx_pkg::RAM_AW'(region.size) << 14) - 1'b1;
   assign rom_size  = msx_pkg::ROM_AW'(region.size) << 14;

   // Stateless mappers
   assign none_addr   = msx_pkg::RAM_AW'(cpu.addr[13:0])
                      + (msx_pkg::RAM_AW'(blk.offset_ram) << 14);
   assign linear_addr = msx_pkg::RAM_AW'(cpu.addr) & size_mask;

   always_comb begin
      case (mapper)
         msx_pkg::MAPPER_NONE:    mapper_offset = none_addr;
         msx_pkg::MAPPER_LINEAR:  mapper_offset = linear_addr;
         msx_pkg::MAPPER_RAM:     mapper_offset = msx_pkg::RAM_AW'(ram_mapper_addr);
         msx_pkg::MAPPER_KONAMI:  mapper_offset = msx_pkg::RAM_AW'(konami_addr);
         msx_pkg::MAPPER_ASCII8:  mapper_offset = msx_pkg::RAM_AW'(ascii8_addr);
         msx_pkg::MAPPER_ASCII16: mapper_offset = msx_pkg::RAM_AW'(ascii16_addr);
         default:                 mapper_offset = '0;
      endcase
   end

   assign ram_addr = region.addr + mapper_offset;
   assign ram_din  = cpu.dout;

   assign mem_unmapped = konami_unmapped | ascii8_unmapped | ascii16_unmapped;

   assign mem_access = cpu.mreq & (mapper != msx_pkg::MAPPER_UNUSED)
                     & ~mem_unmapped & ~expander_hit;
   assign mem_wr     = mem_access & cpu.wr & ~region.ro;   // ROM writes dropped

   assign ram_ce  = (mem_access & cpu.rd) | mem_wr;
   assign ram_rnw = ~mem_wr;

   // Wired-AND read bus, idle sources drive FF
   assign cpu_din = expander_dout
                  & ram_mapper_dout
                  & ((mem_unmapped | ~ram_ce) ? msx_pkg::UNMAPPED_DATA : ram_dout);

   slot_expander i_slot_expander (
      .clk           (clk),
      .reset         (reset),
      .cpu           (cpu),
      .active_slot   (active_slot),
      .bios_config   (bios_config),
      .subslot       (subslot),
      .expander_hit  (expander_hit),
      .expander_dout (expander_dout)
   );

   msx2_ram_mapper i_ram_mapper (
      .clk             (clk),
      .reset           (reset),
      .cpu             (cpu),
      .cs              (mapper == msx_pkg::MAPPER_RAM),
      .ram_block_count (bios_config.ram_block_count),
      .mapper_addr     (ram_mapper_addr),
      .mapper_dout     (ram_mapper_dout)
   );

   cart_konami i_konami (
      .clk          (clk),
      .reset        (reset),
      .cpu          (cpu),
      .cs           (mapper == msx_pkg::MAPPER_KONAMI),
      .rom_size     (rom_size),
      .mem_addr     (konami_addr),
      .mem_unmapped (konami_unmapped)
   );

   cart_ascii8 i_ascii8 (
      .clk          (clk),
      .reset        (reset),
      .cpu          (cpu),
      .cs           (mapper == msx_pkg::MAPPER_ASCII8),
      .rom_size     (rom_size),
      .mem_addr     (ascii8_addr),
      .mem_unmapped (ascii8_unmapped)
   );

   cart_ascii16 i_ascii16 (
      .clk          (clk),
      .reset        (reset),
      .cpu          (cpu),
      .cs           (mapper == msx_pkg::MAPPER_ASCII16),
      .rom_size     (rom_size),
      .mem_addr     (ascii16_addr),
      .mem_unmapped (ascii16_unmapped)
   );

endmodule

`default_nettype wire

/* design/slot_expander.sv */
`default_nettype none
`timescale 1ns/10ps

module slot_expander (
   input  wire                    clk,
   input  wire                    reset,
   input  msx_pkg::cpu_bus_t      cpu,
   input  wire [1:0]              active_slot,
   input  msx_pkg::bios_config_t  bios_config,
   output logic [1:0]             subslot,
   output logic                   expander_hit,
   output logic [7:0]             expander_dout
);

   logic [7:0] slot_reg [4];   // Two bits per page
   logic       expanded;

   assign expanded = bios_config.slot_expander_en[active_slot];

   assign expander_hit = cpu.mreq & expanded & (cpu.addr == msx_pkg::EXPANDER_ADDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            slot_reg[i] <= 8'h00;
         end
      end else if (expander_hit & cpu.wr) begin
         slot_reg[active_slot] <= cpu.dout;
      end
   end

   // Register reads back inverted
   assign expander_dout = (expander_hit & cpu.rd) ? ~slot_reg[active_slot]
                                                  : msx_pkg::UNMAPPED_DATA;

   // Subslot field of the page the CPU is in
   assign subslot = expanded ? slot_reg[active_slot][{cpu.addr[15:14], 1'b0} +: 2] : 2'd0;

endmodule

`default_nettype wire

/* src.f */
design/msx_pkg.sv
design/slot_expander.sv
design/msx2_ram_mapper.sv
design/cart_konami.sv
design/cart_ascii8.sv
design/cart_ascii16.sv
design/msx_slots.sv
verif/tb_msx_slots.sv

/* verif/tb_msx_slots.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_msx_slots;

   localparam int TXNS        = 2000;
   localparam int CYCLE_LIMIT = 6 * TXNS * 2 + 200;
   // Mapper kinds per test, one bit per mapper code
   localparam logic [6:0] TEST_KINDS [7] = '{7'h00, 7'h00, 7'h06, 7'h08, 7'h10, 7'h60, 7'h01};

   logic                       clk = 1'b0;
   logic                       reset;
   msx_pkg::cpu_bus_t          cpu;
   logic [1:0]                 active_slot;
   msx_pkg::block_t            slot_layout [msx_pkg::LAYOUT_ENTRIES];
   msx_pkg::lookup_ram_t       lookup_ram [msx_pkg::RAM_LOOKUPS];
   msx_pkg::bios_config_t      bios_config;
   logic [7:0]                 ram_dout;
   logic [7:0]                 cpu_din;
   logic [msx_pkg::RAM_AW-1:0] ram_addr;
   logic [7:0]                 ram_din;
   logic                       ram_rnw;
   logic                       ram_ce;

   // Model copies of the DUT registers
   logic [7:0] exp_reg [4];
   logic [7:0] seg [4];
   logic [7:0] kon_bank [4];
   logic [7:0] a8_bank [4];
   logic [7:0] a16_bank [2];

   int seed = 32'h928da811;
   int cycle_count = 0;
   int err_count = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   msx_slots i_dut (.*);

   always #2 clk = ~clk;

   function automatic logic [7:0] mem_hash(input logic [26:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'd0, a[26:24]} ^ 8'hA5;
   endfunction

   assign ram_dout = mem_hash(ram_addr);   // Memory content follows the address

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // Predicts the outputs of one access, then applies its register write
   task automatic model_txn(input msx_pkg::cpu_bus_t t, input logic [1:0] slot,
                            output logic [26:0] e_addr, output logic e_ce,
                            output logic e_rnw, output logic [7:0] e_din);
      logic                 exp_hit, port_hit, rom, access, wr_ok;
      logic [1:0]           page, sub, w;
      logic [7:0]           mask, bank;
      logic [26:0]          off, size_mask;
      msx_pkg::block_t      b;
      msx_pkg::lookup_ram_t r;
      page = t.addr[15:14];
      w = {t.addr[15], t.addr[13]};   // 8 kB window in 4000..BFFF
      sub = bios_config.slot_expander_en[slot] ? exp_reg[slot][2*page +: 2] : 2'd0;
      b = slot_layout[{slot, sub, page}];
      r = lookup_ram[b.ref_ram];
      size_mask = 27'(r.size) * 27'd16384 - 27'd1;
      mask = bios_config.ram_block_count - 8'd1;
      exp_hit = t.mreq && bios_config.slot_expander_en[slot] && t.addr == 16'hFFFF;
      port_hit = t.iorq && !t.m1 && t.addr[7:2] == 6'h3F;
      rom = b.mapper == msx_pkg::MAPPER_KONAMI || b.mapper == msx_pkg::MAPPER_ASCII8
            || b.mapper == msx_pkg::MAPPER_ASCII16;
      bank = b.mapper == msx_pkg::MAPPER_ASCII8  ? a8_bank[w] :
             b.mapper == msx_pkg::MAPPER_ASCII16 ? a16_bank[t.addr[15]] :
             (w == 2'd0 ? 8'd0 : kon_bank[w]);
      case (b.mapper)
         msx_pkg::MAPPER_NONE:    off = 27'(t.addr[13:0]) + 27'(b.offset_ram) * 27'd16384;
         msx_pkg::MAPPER_LINEAR:  off = 27'(t.addr) & size_mask;
         msx_pkg::MAPPER_RAM:     off = 27'(seg[page] & mask) * 27'd16384 + 27'(t.addr[13:0]);
         msx_pkg::MAPPER_ASCII16: off = (27'(bank) * 27'd16384 + 27'(t.addr[13:0])) & size_mask;
         default:                 off = (27'(bank) * 27'd8192 + 27'(t.addr[12:0])) & size_mask;
      endcase
      // Cartridges leave pages 0 and 3 unmapped
      access = t.mreq && b.mapper != msx_pkg::MAPPER_UNUSED && !exp_hit
               && !(rom && (page == 2'd0 || page == 2'd3));
      wr_ok = access && t.wr && !r.ro;
      e_ce = (access && t.rd) || wr_ok;
      e_rnw = !wr_ok;
      e_addr = r.addr + off;
      e_din = e_ce ? mem_hash(e_addr) : 8'hFF;
      if (exp_hit && t.rd) e_din &= ~exp_reg[slot];
      if (port_hit && t.rd) e_din &= seg[t.addr[1:0]] | ~mask;
      if (exp_hit && t.wr) exp_reg[slot] = t.dout;
      if (port_hit && t.wr && bios_config.ram_block_count != 8'd0) seg[t.addr[1:0]] = t.dout;
      if (t.mreq && t.wr) begin
         if (b.mapper == msx_pkg::MAPPER_KONAMI && t.addr[15:13] >= 3'd3
             && t.addr[15:13] <= 3'd5)
            kon_bank[w] = t.dout;
         if (b.mapper == msx_pkg::MAPPER_ASCII8 && t.addr[15:13] == 3'd3)
            a8_bank[t.addr[12:11]] = t.dout;
         if (b.mapper == msx_pkg::MAPPER_ASCII16 && t.addr[15:13] == 3'd3 && !t.addr[11])
            a16_bank[t.addr[12]] = t.dout;   // 6000..67FF and 7000..77FF
      end
   endtask

   // One access cycle then one idle cycle, outputs checked at the falling edge
   task automatic apply_txn(input msx_pkg::cpu_bus_t t, input logic [1:0] slot);
      logic [26:0] e_addr;
      logic        e_ce;
      logic        e_rnw;
      logic [7:0]  e_din;
      @(posedge clk);
      cpu <= t;
      active_slot <= slot;
      @(negedge clk);
      model_txn(t, slot, e_addr, e_ce, e_rnw, e_din);
      if (ram_ce !== e_ce || ram_rnw !== e_rnw || (e_ce && ram_addr !== e_addr)
          || (!e_rnw && ram_din !== t.dout) || (t.rd && cpu_din !== e_din)) begin
         $write("[ERROR] %0t: slot %0d addr %h: ce %b rnw %b ram_addr %h",
                $time, slot, t.addr, ram_ce, ram_rnw, ram_addr);
         $write(" ram_din %h cpu_din %h, expected ce %b rnw %b",
                ram_din, cpu_din, e_ce, e_rnw);
         $display(" ram_addr %h ram_din %h cpu_din %h", e_addr, t.dout, e_din);
         err_count++;
      end
      @(posedge clk);
      cpu <= '0;
   endtask

   task automatic build_config();
      logic [31:0] r;
      for (int i = 0; i < msx_pkg::RAM_LOOKUPS; i++) begin
         r = $random(seed);
         // 4 MB apart, so no region of up to 256 blocks overlaps the next
         lookup_ram[i] <= '{addr: 27'(i) << 22, size: 16'd1 << (r[7:0] % 8'd9),
                            ro: r[9:8] == 2'd0};
      end
      for (int i = 0; i < msx_pkg::LAYOUT_ENTRIES; i++) begin
         r = $random(seed);
         slot_layout[i] <= '{ref_ram: r[3:0], offset_ram: r[5:4],
                             mapper: msx_pkg::mapper_t'(3'(r[15:8] % 8'd7)), spare: 1'b0};
      end
      for (int k = 0; k < 7; k++) begin
         slot_layout[(k % 4) * 16 + (k < 4 ? 1 : 2)].mapper <= msx_pkg::mapper_t'(3'(k));
      end
      r = $random(seed);
      bios_config <= '{slot_expander_en: (r[3:0] | 4'b0001) & 4'b1101,   // Slot 0 expanded
                       ram_block_count: 8'd1 << r[10:8]};
   endtask

   task automatic run_test(input int test_id, input string name);
      msx_pkg::cpu_bus_t t;
      msx_pkg::block_t   b;
      logic [31:0]       r;
      logic [7:0]        d;
      logic [5:0]        tgt;
      logic [1:0]        slot;
      int                q[$];
      int                errs_at_start;
      errs_at_start = err_count;
      tgt = '0;
      slot = 2'd0;
      // Reachable blocks of the kinds under test
      for (int i = 0; i < msx_pkg::LAYOUT_ENTRIES; i++) begin
         b = slot_layout[i];
         if ((i[3:2] == 2'd0 || bios_config.slot_expander_en[i[5:4]])
             && (TEST_KINDS[test_id][b.mapper] || (test_id == 6 && lookup_ram[b.ref_ram].ro)))
            q.push_back(i);
      end
      r = $random(seed);
      if (q.size() > 0) tgt = 6'(q[r % q.size()]);
      repeat (TXNS) begin
         r = $random(seed);
         t = '0;
         t.dout = r[31:24];
         t.rd = ~r[0];
         t.wr = r[0];
         if (test_id == 1) begin
            slot = r[2:1];
            t.mreq = 1'b1;
            t.addr = r[3] ? 16'hFFFF : r[23:8];
         end else if (test_id == 3 && r[1]) begin
            slot = active_slot;
            t.iorq = 1'b1;
            t.m1 = r[4:2] == 3'd0;   // Interrupt acknowledge
            t.addr = {r[23:16], 6'h3F, r[6:5]};
         end else begin
            slot = tgt[5:4];
            t.mreq = 1'b1;
            if (bios_config.slot_expander_en[slot]
                && exp_reg[slot][2*tgt[1:0] +: 2] != tgt[3:2]) begin
               d = exp_reg[slot];
               d[2*tgt[1:0] +: 2] = tgt[3:2];   // Select the target subslot first
               t.addr = 16'hFFFF;
               t.dout = d;
               t.rd = 1'b0;
               t.wr = 1'b1;
            end else begin
               t.addr = {tgt[1:0], r[21:8]};
               if (test_id == 5 && r[7]) t.addr[13] = 1'b1;
               r = $random(seed);
               tgt = 6'(q[r % q.size()]);
            end
         end
         apply_txn(t, slot);
      end
      if (err_count == errs_at_start) tests_passed++;
      else tests_failed++;
      $display("Test %0d (%s) finished: %0d transactions, %0d errors",
               test_id, name, TXNS, err_count - errs_at_start);
   endtask

   initial begin
      reset = 1'b1;
      cpu = '0;
      active_slot = 2'd0;
      bios_config = '0;
      slot_layout = '{default: '0};
      lookup_ram = '{default: '0};
      for (int i = 0; i < 4; i++) begin
         exp_reg[i] = 8'd0;
         seg[i] = 8'(3 - i);
         kon_bank[i] = 8'(i);
         a8_bank[i] = 8'd0;
      end
      a16_bank = '{8'd0, 8'd0};
      @(posedge clk);
      build_config();
      repeat (9) @(posedge clk);
      reset <= 1'b0;
      run_test(1, "slot expander");
      run_test(2, "plain and linear blocks");
      run_test(3, "MSX2 RAM mapper");
      run_test(4, "Konami mapper");
      run_test(5, "ASCII8 and ASCII16 mappers");
      run_test(6, "read-only and unused blocks");
      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire
